/* valu_config.svh */
`ifndef VALU_CONFIG_SVH
`define VALU_CONFIG_SVH

// Datapath and sideband widths
`define VALU_DATA_WIDTH 64
`define VALU_ADDR_WIDTH 32
`define VALU_VL_WIDTH   8
`define VALU_OFF_WIDTH  8
`define VALU_BE_WIDTH   (`VALU_DATA_WIDTH / 8)

// Pipeline depth in clock edges, counted from the edge that samples the request
`define VALU_UNIT_LATENCY 3
`define VALU_RESP_LATENCY 4

`endif

/* source/valu_isa_pkg.sv */
`default_nettype none

package valu_isa_pkg;

    // Function codes of the supported integer ops
    typedef enum logic [5:0] {
        FUNC_ADD   = 6'b000000,
        FUNC_SUB   = 6'b000010,
        FUNC_RSUB  = 6'b000011,
        FUNC_MINU  = 6'b000100,
        FUNC_MIN   = 6'b000101,
        FUNC_MAXU  = 6'b000110,
        FUNC_MAX   = 6'b000111,
        FUNC_AND   = 6'b001001,
        FUNC_OR    = 6'b001010,
        FUNC_XOR   = 6'b001011,
        FUNC_MULHU = 6'b100100,
        FUNC_MUL   = 6'b100101
    } func_id_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,  // data0 - data1
        ALU_RSUB, // data1 - data0
        ALU_MINU,
        ALU_MIN,
        ALU_MAXU,
        ALU_MAX,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef enum logic {
        MUL_LO,
        MUL_HIU
    } mul_op_t;

endpackage

`default_nettype wire

/* source/valu_data_pkg.sv */
`default_nettype none

`include "valu_config.svh"

package valu_data_pkg;

    typedef logic [`VALU_DATA_WIDTH-1:0] vec_t;
    typedef logic [`VALU_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`VALU_BE_WIDTH-1:0]   be_t;

    // Request fields that bypass the units
    typedef struct packed {
        logic                       is_start;
        logic                       is_end;
        be_t                        be;
        logic [`VALU_VL_WIDTH-1:0]  vl;
        logic [`VALU_OFF_WIDTH-1:0] off;
    } sideband_t;

endpackage

`default_nettype wire

/* source/valu_delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    logic [DEPTH-1:0] valid_q;
    payload_t         data_q [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            for (int i = 0; i < DEPTH; i++) data_q[i] <= '0;
        end else begin
            valid_q[0] <= in_valid;
            data_q[0]  <= in_valid ? in_data : '0; // Idle slots carry zero
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
                data_q[i]  <= data_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

/* source/valu_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module valu_decoder import valu_isa_pkg::*; (
    input  logic     req_valid,
    input  func_id_t req_func_id,
    output logic     alu_valid,
    output alu_op_t  alu_op,
    output logic     mul_valid,
    output mul_op_t  mul_op,
    output logic     op_valid
);

    logic alu_hit;
    logic mul_hit;

    always_comb begin
        alu_hit = 1'b1;
        mul_hit = 1'b0;
        alu_op  = ALU_ADD;
        mul_op  = MUL_LO;
        case (req_func_id)
            FUNC_ADD:  alu_op = ALU_ADD;
            FUNC_SUB:  alu_op = ALU_SUB;
            FUNC_RSUB: alu_op = ALU_RSUB;
            FUNC_MINU: alu_op = ALU_MINU;
            FUNC_MIN:  alu_op = ALU_MIN;
            FUNC_MAXU: alu_op = ALU_MAXU;
            FUNC_MAX:  alu_op = ALU_MAX;
            FUNC_AND:  alu_op = ALU_AND;
            FUNC_OR:   alu_op = ALU_OR;
            FUNC_XOR:  alu_op = ALU_XOR;
            FUNC_MUL: begin
                alu_hit = 1'b0;
                mul_hit = 1'b1;
                mul_op  = MUL_LO;
            end
            FUNC_MULHU: begin
                alu_hit = 1'b0;
                mul_hit = 1'b1;
                mul_op  = MUL_HIU;
            end
            default: alu_hit = 1'b0; // Unsupported code goes nowhere
        endcase
    end

    assign alu_valid = req_valid & alu_hit;
    assign mul_valid = req_valid & mul_hit;
    assign op_valid  = alu_valid | mul_valid;

endmodule

`default_nettype wire

/* source/valu_int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module valu_int_alu import valu_isa_pkg::*, valu_data_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  alu_op_t in_op,
    input  sew_t    in_sew,
    input  vec_t    in_data0,
    input  vec_t    in_data1,
    input  addr_t   in_addr,
    output logic    out_valid,
    output vec_t    out_vec,
    output addr_t   out_addr
);

    alu_op_t s1_op;
    sew_t    s1_sew;
    vec_t    s1_data0;
    vec_t    s1_data1;
    vec_t    lane_res;
    vec_t    s2_res;
    logic    dl_valid;
    addr_t   dl_addr;

    // One lane held in the low bits, result masked to the lane width
    function automatic vec_t lane_calc(input vec_t a_in, input vec_t b_in,
                                       input alu_op_t op, input sew_t sew);
        vec_t mask;
        vec_t sign;
        vec_t a;
        vec_t b;
        vec_t res;
        logic lt_u;
        logic lt_s;
        mask = (sew == SEW_64) ? '1 : ((vec_t'(1) << (8 << sew)) - vec_t'(1));
        sign = mask ^ (mask >> 1);
        a    = a_in & mask;
        b    = b_in & mask;
        lt_u = a < b;
        lt_s = (a ^ sign) < (b ^ sign); // Sign flip turns signed into unsigned compare
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_RSUB: res = b - a;
            ALU_MINU: res = lt_u ? a : b;
            ALU_MIN:  res = lt_s ? a : b;
            ALU_MAXU: res = lt_u ? b : a;
            ALU_MAX:  res = lt_s ? b : a;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            default:  res = '0;
        endcase
        return res & mask;
    endfunction

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_op    <= in_op;
            s1_sew   <= in_sew;
            s1_data0 <= in_data0;
            s1_data1 <= in_data1;
        end
        s2_res <= lane_res;
    end

    always_comb begin
        lane_res = '0;
        for (int i = 0; i < `VALU_BE_WIDTH; i++) begin
            if (i < (`VALU_BE_WIDTH >> s1_sew)) begin
                lane_res = lane_res | (lane_calc(s1_data0 >> ((i * 8) << s1_sew),
                                                 s1_data1 >> ((i * 8) << s1_sew),
                                                 s1_op, s1_sew) << ((i * 8) << s1_sew));
            end
        end
    end

    // Valid and address wait beside stages 1 and 2
    valu_delay_line #(
        .payload_t (addr_t),
        .DEPTH     (`VALU_UNIT_LATENCY - 1)
    ) addr_dl_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_addr),
        .out_valid (dl_valid),
        .out_data  (dl_addr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dl_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_vec  <= dl_valid ? s2_res : '0;
        out_addr <= dl_addr;
    end

endmodule

`default_nettype wire

/* source/valu_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module valu_mul import valu_isa_pkg::*, valu_data_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  mul_op_t in_op,
    input  sew_t    in_sew,
    input  vec_t    in_data0,
    input  vec_t    in_data1,
    input  addr_t   in_addr,
    output logic    out_valid,
    output vec_t    out_vec,
    output addr_t   out_addr
);

    localparam int DW = `VALU_DATA_WIDTH;

    mul_op_t          s1_op;
    sew_t             s1_sew;
    vec_t             s1_data0;
    vec_t             s1_data1;
    mul_op_t          s2_op;
    sew_t             s2_sew;
    logic [2*DW-1:0]  prod_d; // Lane i of width 2*SEW at offset i*2*SEW
    logic [2*DW-1:0]  prod_q;
    vec_t             res_d;
    logic             hi_sel;
    logic             dl_valid;
    addr_t            dl_addr;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_op    <= in_op;
            s1_sew   <= in_sew;
            s1_data0 <= in_data0;
            s1_data1 <= in_data1;
        end
        s2_op  <= s1_op;
        s2_sew <= s1_sew;
        prod_q <= prod_d;
    end

    always_comb begin
        prod_d = '0;
        case (s1_sew)
            SEW_8:
                for (int i = 0; i < DW / 8; i++)
                    prod_d[i*16 +: 16] = 16'(s1_data0[i*8 +: 8]) * 16'(s1_data1[i*8 +: 8]);
            SEW_16:
                for (int i = 0; i < DW / 16; i++)
                    prod_d[i*32 +: 32] = 32'(s1_data0[i*16 +: 16]) * 32'(s1_data1[i*16 +: 16]);
            SEW_32:
                for (int i = 0; i < DW / 32; i++)
                    prod_d[i*64 +: 64] = 64'(s1_data0[i*32 +: 32]) * 64'(s1_data1[i*32 +: 32]);
            default:
                prod_d = (2*DW)'(s1_data0) * (2*DW)'(s1_data1);
        endcase
    end

    assign hi_sel = (s2_op == MUL_HIU);

    // Low half wraps within the lane, high half is the unsigned upper part
    always_comb begin
        res_d = '0;
        case (s2_sew)
            SEW_8:
                for (int i = 0; i < DW / 8; i++)
                    res_d[i*8 +: 8] = hi_sel ? prod_q[i*16+8 +: 8] : prod_q[i*16 +: 8];
            SEW_16:
                for (int i = 0; i < DW / 16; i++)
                    res_d[i*16 +: 16] = hi_sel ? prod_q[i*32+16 +: 16] : prod_q[i*32 +: 16];
            SEW_32:
                for (int i = 0; i < DW / 32; i++)
                    res_d[i*32 +: 32] = hi_sel ? prod_q[i*64+32 +: 32] : prod_q[i*64 +: 32];
            default:
                res_d = hi_sel ? prod_q[DW +: DW] : prod_q[0 +: DW];
        endcase
    end

    valu_delay_line #(
        .payload_t (addr_t),
        .DEPTH     (`VALU_UNIT_LATENCY - 1)
    ) addr_dl_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_addr),
        .out_valid (dl_valid),
        .out_data  (dl_addr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dl_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_vec  <= dl_valid ? res_d : '0;
        out_addr <= dl_addr;
    end

endmodule

`default_nettype wire

/* source/valu_resp_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module valu_resp_merge import valu_data_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alu_valid,
    input  vec_t                       alu_vec,
    input  addr_t                      alu_addr,
    input  logic                       mul_valid,
    input  vec_t                       mul_vec,
    input  addr_t                      mul_addr,
    input  logic                       side_valid,
    input  sideband_t                  side,
    output logic                       resp_valid,
    output vec_t                       resp_data,
    output addr_t                      resp_addr,
    output be_t                        resp_be,
    output logic [`VALU_VL_WIDTH-1:0]  resp_vl,
    output logic [`VALU_OFF_WIDTH-1:0] resp_off,
    output logic                       resp_start,
    output logic                       resp_end
);

    vec_t be_mask;

    // Byte enable widened to a bit mask
    always_comb begin
        for (int i = 0; i < `VALU_BE_WIDTH; i++) be_mask[i*8 +: 8] = {8{side.be[i]}};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
        end else begin
            resp_valid <= alu_valid | mul_valid;
            resp_start <= side_valid & side.is_start;
            resp_end   <= side_valid & side.is_end;
        end
    end

    // Idle units drive zero so a plain OR selects the active one
    always_ff @(posedge clk) begin
        resp_data <= (alu_vec | mul_vec) & be_mask;
        resp_addr <= alu_addr | mul_addr;
        resp_be   <= side.be;
        resp_vl   <= side.vl;
        resp_off  <= side.off;
    end

endmodule

`default_nettype wire

/* source/valu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module valu_top import valu_isa_pkg::*, valu_data_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    input  func_id_t                   req_func_id,
    input  sew_t                       req_sew,
    input  vec_t                       req_data0,
    input  vec_t                       req_data1,
    input  addr_t                      req_addr,
    input  be_t                        req_be,
    input  logic [`VALU_VL_WIDTH-1:0]  req_vl,
    input  logic                       req_start,
    input  logic                       req_end,
    input  logic [`VALU_OFF_WIDTH-1:0] req_off,
    output logic                       resp_valid,
    output vec_t                       resp_data,
    output addr_t                      resp_addr,
    output be_t                        resp_be,
    output logic [`VALU_VL_WIDTH-1:0]  resp_vl,
    output logic [`VALU_OFF_WIDTH-1:0] resp_off,
    output logic                       resp_start,
    output logic                       resp_end
);

    logic      alu_en;
    alu_op_t   alu_op;
    logic      mul_en;
    mul_op_t   mul_op;
    logic      op_valid;
    logic      alu_out_valid;
    vec_t      alu_out_vec;
    addr_t     alu_out_addr;
    logic      mul_out_valid;
    vec_t      mul_out_vec;
    addr_t     mul_out_addr;
    sideband_t side_in;
    logic      side_valid;
    sideband_t side_out;

    assign side_in = '{is_start: req_start, is_end: req_end, be: req_be,
                       vl: req_vl, off: req_off};

    valu_decoder decoder_i (
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .alu_valid   (alu_en),
        .alu_op      (alu_op),
        .mul_valid   (mul_en),
        .mul_op      (mul_op),
        .op_valid    (op_valid)
    );

    valu_int_alu int_alu_i (
        .clk (clk), .rst (rst),
        .in_valid (alu_en), .in_op (alu_op), .in_sew (req_sew),
        .in_data0 (req_data0), .in_data1 (req_data1), .in_addr (req_addr),
        .out_valid (alu_out_valid), .out_vec (alu_out_vec), .out_addr (alu_out_addr)
    );

    valu_mul mul_i (
        .clk (clk), .rst (rst),
        .in_valid (mul_en), .in_op (mul_op), .in_sew (req_sew),
        .in_data0 (req_data0), .in_data1 (req_data1), .in_addr (req_addr),
        .out_valid (mul_out_valid), .out_vec (mul_out_vec), .out_addr (mul_out_addr)
    );

    // Sideband lines up with the unit outputs
    valu_delay_line #(
        .payload_t (sideband_t),
        .DEPTH     (`VALU_UNIT_LATENCY)
    ) side_dl_i (
        .clk (clk), .rst (rst),
        .in_valid (op_valid), .in_data (side_in),
        .out_valid (side_valid), .out_data (side_out)
    );

    valu_resp_merge merge_i (
        .clk (clk), .rst (rst),
        .alu_valid (alu_out_valid), .alu_vec (alu_out_vec), .alu_addr (alu_out_addr),
        .mul_valid (mul_out_valid), .mul_vec (mul_out_vec), .mul_addr (mul_out_addr),
        .side_valid (side_valid), .side (side_out),
        .resp_valid (resp_valid), .resp_data (resp_data), .resp_addr (resp_addr),
        .resp_be (resp_be), .resp_vl (resp_vl), .resp_off (resp_off),
        .resp_start (resp_start), .resp_end (resp_end)
    );

endmodule

`default_nettype wire

/* test/tb_valu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module tb_valu import valu_isa_pkg::*, valu_data_pkg::*;;

    localparam int PERIOD    = 100;
    localparam int DW        = `VALU_DATA_WIDTH;
    localparam int NUM_TESTS = 7;
    localparam int TOTAL_REQ = 28 + 32 + 12 + 24 + 12 + 1;
    // Reset, every request, per-test drain slack and a margin
    localparam int WATCHDOG_CYCLES = 5 + TOTAL_REQ + NUM_TESTS * 12 + 50;

    typedef logic [`VALU_VL_WIDTH-1:0]  vl_t;
    typedef logic [`VALU_OFF_WIDTH-1:0] off_t;

    logic      clk;
    logic      rst;
    logic      req_valid;
    func_id_t  req_func_id;
    sew_t      req_sew;
    vec_t      req_data0;
    vec_t      req_data1;
    addr_t     req_addr;
    be_t       req_be;
    vl_t       req_vl;
    logic      req_start;
    logic      req_end;
    off_t      req_off;
    logic      resp_valid;
    vec_t      resp_data;
    addr_t     resp_addr;
    be_t       resp_be;
    vl_t       resp_vl;
    off_t      resp_off;
    logic      resp_start;
    logic      resp_end;
    sideband_t resp_side;

    int        seed      = 32'heb5a1223;
    int        cycle     = 0; // Edges seen, updated on the falling edge
    int        errors    = 0;
    int        tests_run = 0;
    int        err_mark  = 0;
    string     test_name = "";
    addr_t     next_addr = 32'h1000;

    // Expected responses in request order
    int        exp_due[$];
    vec_t      exp_data[$];
    addr_t     exp_addr[$];
    sideband_t exp_side[$];

    valu_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_vl      (req_vl),
        .req_start   (req_start),
        .req_end     (req_end),
        .req_off     (req_off),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .resp_be     (resp_be),
        .resp_vl     (resp_vl),
        .resp_off    (resp_off),
        .resp_start  (resp_start),
        .resp_end    (resp_end)
    );

    assign resp_side = '{is_start: resp_start, is_end: resp_end, be: resp_be,
                         vl: resp_vl, off: resp_off};

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // One bit set at the bottom of every lane
    function automatic vec_t lane_lsb(input sew_t sew);
        vec_t v;
        int   i;
        v = '0;
        for (i = 0; i < DW; i += (8 << sew)) begin
            v[i] = 1'b1;
        end
        return v;
    endfunction

    function automatic vec_t ref_result(input func_id_t func, input sew_t sew,
                                        input vec_t a, input vec_t b);
        int                 w;
        int                 i;
        logic [DW-1:0]      mask;
        logic [DW-1:0]      x;
        logic [DW-1:0]      y;
        logic [DW-1:0]      r;
        logic signed [DW-1:0] xs;
        logic signed [DW-1:0] ys;
        logic [2*DW-1:0]    p;
        vec_t               res;
        w    = 8 << sew;
        mask = (w == DW) ? '1 : ((64'd1 << w) - 64'd1);
        res  = '0;
        for (i = 0; i < DW / w; i++) begin
            x  = (a >> (i * w)) & mask;
            y  = (b >> (i * w)) & mask;
            xs = $signed(x << (DW - w)) >>> (DW - w); // Sign extended lane
            ys = $signed(y << (DW - w)) >>> (DW - w);
            p  = {{DW{1'b0}}, x} * {{DW{1'b0}}, y};
            case (func)
                FUNC_ADD:   r = x + y;
                FUNC_SUB:   r = x - y;
                FUNC_RSUB:  r = y - x;
                FUNC_MINU:  r = (x < y) ? x : y;
                FUNC_MIN:   r = (xs < ys) ? x : y;
                FUNC_MAXU:  r = (x > y) ? x : y;
                FUNC_MAX:   r = (xs > ys) ? x : y;
                FUNC_AND:   r = x & y;
                FUNC_OR:    r = x | y;
                FUNC_XOR:   r = x ^ y;
                FUNC_MUL:   r = p[DW-1:0];
                FUNC_MULHU: r = DW'(p >> w);
                default:    r = '0;
            endcase
            res = res | ((r & mask) << (i * w));
        end
        return res;
    endfunction

    function automatic vec_t apply_be(input vec_t v, input be_t be);
        int i;
        for (i = 0; i < `VALU_BE_WIDTH; i++) begin
            if (!be[i]) v[i*8 +: 8] = 8'h00;
        end
        return v;
    endfunction

    function automatic vec_t rand_vec();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic sideband_t make_side(input be_t be);
        sideband_t sb;
        int        r;
        r           = $random(seed);
        sb.is_start = r[0];
        sb.is_end   = r[1];
        sb.be       = be;
        sb.vl       = vl_t'(r >> 8);
        sb.off      = off_t'(r >> 16);
        return sb;
    endfunction

    task automatic check_vec(input vec_t got, input vec_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s data got %h expected %h", $time, test_name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s addr got %h expected %h", $time, test_name, got, exp);
            errors++;
        end
    endtask

    task automatic check_side(input sideband_t got, input sideband_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s sideband got s=%b e=%b be=%h vl=%0d off=%0d",
                     $time, test_name, got.is_start, got.is_end, got.be, got.vl, got.off);
            $display("       expected s=%b e=%b be=%h vl=%0d off=%0d",
                     exp.is_start, exp.is_end, exp.be, exp.vl, exp.off);
            errors++;
        end
    endtask

    task automatic pop_expected();
        void'(exp_due.pop_front());
        void'(exp_data.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_side.pop_front());
    endtask

    // Drive one request on the next rising edge and queue its response
    task automatic send_req(input func_id_t func, input sew_t sew, input vec_t a,
                            input vec_t b, input sideband_t sb);
        @(posedge clk);
        req_valid   <= 1'b1;
        req_func_id <= func;
        req_sew     <= sew;
        req_data0   <= a;
        req_data1   <= b;
        req_addr    <= next_addr;
        req_be      <= sb.be;
        req_vl      <= sb.vl;
        req_off     <= sb.off;
        req_start   <= sb.is_start;
        req_end     <= sb.is_end;
        exp_due.push_back(cycle + 1 + `VALU_RESP_LATENCY);
        exp_data.push_back(apply_be(ref_result(func, sew, a, b), sb.be));
        exp_addr.push_back(next_addr);
        exp_side.push_back(sb);
        next_addr += 8;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        req_valid <= 1'b0;
        while (exp_due.size() != 0 && waited < 4 * `VALU_RESP_LATENCY) begin
            @(posedge clk);
            waited++;
        end
        if (exp_due.size() != 0) begin
            $display("%s: %0d responses never arrived", test_name, exp_due.size());
            errors++;
            exp_due.delete();
            exp_data.delete();
            exp_addr.delete();
            exp_side.delete();
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        if (errors == err_mark) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, errors - err_mark);
        end
    endtask

    // Response checker, sampled away from the rising edge
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (resp_valid === 1'b1) begin
            if (exp_due.size() == 0) begin
                $display("Response at %0t ns with no request outstanding", $time);
                errors++;
            end else begin
                if (cycle != exp_due[0]) begin
                    $display("Response at cycle %0d, expected at cycle %0d", cycle, exp_due[0]);
                    errors++;
                end
                check_vec(resp_data, exp_data[0]);
                check_addr(resp_addr, exp_addr[0]);
                check_side(resp_side, exp_side[0]);
                pop_expected();
            end
        end else if (exp_due.size() != 0 && cycle > exp_due[0]) begin
            $display("No response for the request due at cycle %0d", exp_due[0]);
            errors++;
            pop_expected();
        end
    end

    task automatic test_reset_idle();
        start_test("reset_idle");
        @(negedge clk);
        if (resp_valid !== 1'b0 || resp_start !== 1'b0 || resp_end !== 1'b0) begin
            $display("[FAIL] %0t ns: response outputs not low after reset", $time);
            errors++;
        end
        end_test();
    endtask

    task automatic test_add_sub();
        func_id_t funcs [3];
        int       s;
        int       f;
        funcs = '{FUNC_ADD, FUNC_SUB, FUNC_RSUB};
        start_test("add_sub");
        for (s = 0; s < 4; s++) begin
            for (f = 0; f < 3; f++) begin
                repeat (2) send_req(funcs[f], sew_t'(s), rand_vec(), rand_vec(), make_side('1));
            end
            // All ones plus one wraps to zero in each lane
            send_req(FUNC_ADD, sew_t'(s), '1, lane_lsb(sew_t'(s)), make_side('1));
        end
        end_test();
    endtask

    task automatic test_min_max();
        func_id_t funcs [4];
        vec_t     signs;
        vec_t     a;
        int       s;
        int       f;
        funcs = '{FUNC_MINU, FUNC_MIN, FUNC_MAXU, FUNC_MAX};
        start_test("min_max");
        for (s = 0; s < 4; s++) begin
            signs = lane_lsb(sew_t'(s)) << ((8 << s) - 1);
            for (f = 0; f < 4; f++) begin
                repeat (2) begin
                    a = rand_vec();
                    send_req(funcs[f], sew_t'(s), a, (rand_vec() & ~signs) | (~a & signs),
                             make_side('1));
                end
            end
        end
        end_test();
    endtask

    task automatic test_logic();
        func_id_t funcs [3];
        int       f;
        funcs = '{FUNC_AND, FUNC_OR, FUNC_XOR};
        start_test("logic");
        for (f = 0; f < 3; f++) begin
            repeat (4) send_req(funcs[f], SEW_64, rand_vec(), rand_vec(), make_side('1));
        end
        end_test();
    endtask

    task automatic test_mul();
        int s;
        start_test("mul");
        for (s = 0; s < 4; s++) begin
            repeat (3) send_req(FUNC_MUL, sew_t'(s), rand_vec(), rand_vec(), make_side('1));
            repeat (3) send_req(FUNC_MULHU, sew_t'(s), rand_vec(), rand_vec(), make_side('1));
        end
        end_test();
    endtask

    task automatic test_burst();
        func_id_t  funcs [6];
        sideband_t sb;
        int        i;
        funcs = '{FUNC_ADD, FUNC_MUL, FUNC_MAX, FUNC_MULHU, FUNC_XOR, FUNC_RSUB};
        start_test("burst");
        for (i = 0; i < 12; i++) begin
            sb          = make_side(be_t'($random(seed)));
            sb.is_start = (i == 0);
            sb.is_end   = (i == 11);
            send_req(funcs[i % 6], sew_t'(i % 4), rand_vec(), rand_vec(), sb);
        end
        end_test();
    endtask

    task automatic test_unsupported();
        int n;
        start_test("unsupported");
        @(posedge clk);
        req_valid   <= 1'b1;
        req_func_id <= func_id_t'(6'b111111);
        @(posedge clk);
        req_valid <= 1'b0;
        for (n = 0; n < 7; n++) begin
            @(negedge clk);
            if (resp_valid !== 1'b0) begin
                $display("[FAIL] %0t ns: resp_valid high after unsupported code", $time);
                errors++;
            end
        end
        end_test();
    endtask

    initial begin
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_func_id = FUNC_ADD;
        req_sew     = SEW_8;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_be      = '0;
        req_vl      = '0;
        req_start   = 1'b0;
        req_end     = 1'b0;
        req_off     = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset_idle();
        test_add_sub();
        test_min_max();
        test_logic();
        test_mul();
        test_burst();
        test_unsupported();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
source/valu_isa_pkg.sv
source/valu_data_pkg.sv
source/valu_delay_line.sv
source/valu_decoder.sv
source/valu_int_alu.sv
source/valu_mul.sv
source/valu_resp_merge.sv
source/valu_top.sv
test/tb_valu.sv

/* Makefile */
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_valu
RTL_TOP    ?= valu_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
